/* Makefile */
TB := poly_mul_tb

SOURCES := poly_mul_top.f common/poly_mul_macros.svh common/poly_mul_pkg.sv \
           rtl/limb_repack.sv rtl/product_array.sv rtl/carry_save_tree.sv \
           rtl/column_reduce.sv rtl/poly_mul_top.sv bench/poly_mul_tb.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f poly_mul_top.f --top-module poly_mul_top

obj_dir/V$(TB): $(SOURCES)
	verilator --binary --timing --assert -f poly_mul_top.f --top-module $(TB) -o V$(TB)

sim: obj_dir/V$(TB)
	./obj_dir/V$(TB) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/poly_mul_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "poly_mul_macros.svh"

module poly_mul_tb;

   typedef logic [159:0] wide_t;

   localparam int RESET_CYCLES = 5;
   localparam int NUM_RANDOM   = 300;
   // Reset, about 30 directed operands, the random run, then margin
   localparam int DIRECTED_OPS = 30;
   localparam int CYCLE_LIMIT  = RESET_CYCLES + DIRECTED_OPS + NUM_RANDOM + 65;

   logic                   clk;
   logic                   arst_n;
   poly_mul_pkg::operand_t operand;
   poly_mul_pkg::result_t  result;

   integer                 seed;
   int                     errors;
   int                     checks;
   int                     cycle_count;
   int                     fill_count;
   wide_t                  expected_q[$];
   wide_t                  exp_value;
   wide_t                  got_value;
   poly_mul_pkg::operand_t stim;

   poly_mul_top i_poly_mul_top (
      .clk     (clk),
      .arst_n  (arst_n),
      .operand (operand),
      .result  (result)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Integer value of each operand from its limbs, then the plain product
   function automatic wide_t ref_product(input poly_mul_pkg::operand_t op);
      wide_t a_val;
      wide_t b_val;
      a_val = '0;
      b_val = '0;
      for (int i = 0; i < `POLY_NUM_LIMBS; i++) begin
         a_val = a_val + (wide_t'(op.a[i]) << (`POLY_RADIX * i));
         b_val = b_val + (wide_t'(op.b[i]) << (`POLY_RADIX * i));
      end
      return a_val * b_val;
   endfunction

   // Each column pair is exact modulo the column width
   function automatic wide_t weighted_sum(input poly_mul_pkg::result_t r);
      wide_t                 total;
      poly_mul_pkg::column_t col;
      total = '0;
      for (int k = 0; k < `POLY_NUM_COLS; k++) begin
         col   = r.s[k] + r.cout[k];
         total = total + (wide_t'(col) << (`POLY_RADIX * k));
      end
      return total;
   endfunction

   task automatic drive_op(input poly_mul_pkg::operand_t op);
      @(posedge clk);
      operand <= op;
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   // Compare on the falling edge, where operand and result are both settled
   always @(negedge clk) begin
      if (!arst_n) begin
         expected_q.delete();
         for (int i = 0; i < 3; i++) begin
            expected_q.push_back('0);
         end
         fill_count = 0;
         assert (result == '0) else begin
            errors++;
            $display("Error: result = %h during reset, expected 0", result);
         end
      end else begin
         exp_value = expected_q.pop_front();
         got_value = weighted_sum(result);
         checks++;
         if (fill_count < 3) begin
            fill_count++;
            assert (result == '0) else begin
               errors++;
               $display("Error: result = %h while the pipeline fills, expected 0", result);
            end
         end
         assert (got_value == exp_value) else begin
            errors++;
            $display("Error: result weighted sum = %h, expected %h", got_value, exp_value);
         end
         assert (result.cout[0] == '0) else begin
            errors++;
            $display("Error: result.cout[0] = %h, expected 0", result.cout[0]);
         end
         assert (result.cout[`POLY_NUM_COLS-1] == '0) else begin
            errors++;
            $display("Error: result.cout[%0d] = %h, expected 0",
                     `POLY_NUM_COLS - 1, result.cout[`POLY_NUM_COLS-1]);
         end
         expected_q.push_back(ref_product(operand));
      end
   end

   initial begin
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
      end
      $display("Run timed out after %0d clock cycles before the tests finished", cycle_count);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      seed        = 9431;
      errors      = 0;
      checks      = 0;
      cycle_count = 0;
      fill_count  = 0;
      arst_n      = 1'b0;
      // Nonzero operand during reset, the result must still read zero
      operand     = '1;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;

      // Zero and all-ones limbs, the latter drive every spilled bit 16
      stim = '0;
      drive_op(stim);
      stim = '1;
      drive_op(stim);
      stim   = '0;
      stim.a = '1;
      drive_op(stim);
      stim   = '0;
      stim.b = '1;
      drive_op(stim);

      // One A limb against one B limb for every position pair
      for (int i = 0; i < `POLY_NUM_LIMBS; i++) begin
         for (int j = 0; j < `POLY_NUM_LIMBS; j++) begin
            stim      = '0;
            stim.a[i] = 17'h1a5c3 ^ poly_mul_pkg::limb_t'(i);
            stim.b[j] = 17'h13c96 ^ poly_mul_pkg::limb_t'(j);
            drive_op(stim);
         end
      end

      // Spill bit alone, folded into the next large word
      for (int i = 0; i < `POLY_NUM_LIMBS; i++) begin
         stim      = '0;
         stim.a[i] = 17'h10000;
         stim.b[0] = 17'h00001;
         drive_op(stim);
      end

      for (int n = 0; n < NUM_RANDOM; n++) begin
         for (int i = 0; i < `POLY_NUM_LIMBS; i++) begin
            stim.a[i] = poly_mul_pkg::limb_t'($random(seed));
            stim.b[i] = poly_mul_pkg::limb_t'($random(seed));
         end
         drive_op(stim);
      end

      // Let the last operands reach the result
      repeat (5) @(posedge clk);
      $display("Result checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* common/poly_mul_macros.svh */
`ifndef POLY_MUL_MACROS_SVH
`define POLY_MUL_MACROS_SVH

// Operand limbs, A and B use the same layout
`define POLY_NUM_LIMBS 4
`define POLY_LIMB_BITS 17
`define POLY_RADIX     16

// Large words that A is folded into before the multipliers
`define POLY_LG_RADIX  25
`define POLY_LG_BITS   26

// Ceiling of the A bit span over the large-word radix
`define POLY_NUM_LG \
   (((`POLY_NUM_LIMBS * `POLY_RADIX) + `POLY_LG_RADIX - 1) / `POLY_LG_RADIX)

// Reduction grid size for this configuration
`define POLY_NUM_COLS  9
`define POLY_NUM_ROWS  10

// Column words have headroom for twice the limb count of radix words
`define POLY_COL_BITS  (`POLY_RADIX + $clog2(2 * `POLY_NUM_LIMBS))

`endif

/* common/poly_mul_pkg.sv */
`default_nettype none

`include "poly_mul_macros.svh"

package poly_mul_pkg;

   typedef logic [`POLY_LIMB_BITS-1:0]                  limb_t;
   typedef logic [`POLY_LG_BITS-1:0]                    large_word_t;
   typedef logic [`POLY_LG_BITS+`POLY_LIMB_BITS-1:0]    product_t;
   typedef logic [`POLY_COL_BITS-1:0]                   column_t;

   typedef struct packed {
      limb_t [`POLY_NUM_LIMBS-1:0] a;
      limb_t [`POLY_NUM_LIMBS-1:0] b;
   } operand_t;

   typedef struct packed {
      large_word_t [`POLY_NUM_LG-1:0]    lg;
      limb_t       [`POLY_NUM_LIMBS-1:0] b;
   } lg_operand_t;

   // First index is the large word, second the B limb
   typedef product_t [`POLY_NUM_LG-1:0][`POLY_NUM_LIMBS-1:0] product_grid_t;

   typedef struct packed {
      column_t [`POLY_NUM_COLS-1:0] cout;
      column_t [`POLY_NUM_COLS-1:0] s;
   } result_t;

   // Bit position of large word k inside its starting limb
   function automatic int lg_offset_of(int k);
      return (k * (`POLY_LG_RADIX - `POLY_RADIX)) % `POLY_RADIX;
   endfunction

   function automatic int lg_index_of(int k);
      return (k * `POLY_LG_RADIX) / `POLY_RADIX;
   endfunction

   // A word needs a fourth row when its product spills past the third slice
   function automatic int grid_row_of(int k);
      int row;
      row = 0;
      for (int i = 0; i < k; i++) begin
         if (($bits(product_t) - 2 * `POLY_RADIX) > (`POLY_RADIX - lg_offset_of(i))) begin
            row += 4;
         end else begin
            row += 3;
         end
      end
      return row;
   endfunction

endpackage

`default_nettype wire

/* poly_mul_top.f */
+incdir+common
common/poly_mul_pkg.sv
rtl/limb_repack.sv
rtl/product_array.sv
rtl/carry_save_tree.sv
rtl/column_reduce.sv
rtl/poly_mul_top.sv
bench/poly_mul_tb.sv

/* rtl/carry_save_tree.sv */
`timescale 1ns/1ps
`default_nettype none

`include "poly_mul_macros.svh"

module carry_save_tree (
   input  poly_mul_pkg::column_t [`POLY_NUM_ROWS-1:0] terms,
   output poly_mul_pkg::column_t                      c,
   output poly_mul_pkg::column_t                      s
);

   poly_mul_pkg::column_t term_sum;

   always_comb begin
      poly_mul_pkg::column_t [`POLY_NUM_ROWS-1:0] work;
      poly_mul_pkg::column_t [`POLY_NUM_ROWS-1:0] reduced;
      int cnt;
      int nxt;
      work = terms;
      cnt  = `POLY_NUM_ROWS;
      // Layers past the last useful one just pass the two words along
      for (int layer = 0; layer < `POLY_NUM_ROWS; layer++) begin
         reduced = '0;
         nxt     = 0;
         // Full groups of three become a sum and a shifted carry
         for (int g = 0; g + 2 < `POLY_NUM_ROWS; g += 3) begin
            if (g + 2 < cnt) begin
               reduced[nxt]   = work[g] ^ work[g+1] ^ work[g+2];
               reduced[nxt+1] = ((work[g] & work[g+1]) |
                                 (work[g] & work[g+2]) |
                                 (work[g+1] & work[g+2])) << 1;
               nxt += 2;
            end
         end
         // Leftover rows go to the next layer untouched
         for (int g = 0; g < `POLY_NUM_ROWS; g++) begin
            if (g >= cnt - cnt % 3 && g < cnt) begin
               reduced[nxt] = work[g];
               nxt++;
            end
         end
         work = reduced;
         cnt  = nxt;
      end
      s = work[0];
      c = work[1];
   end

   always_comb begin
      term_sum = '0;
      for (int i = 0; i < `POLY_NUM_ROWS; i++) begin
         term_sum = term_sum + terms[i];
      end
   end

   // Whole tree must preserve the column total
   always_comb begin
      assert final (poly_mul_pkg::column_t'(s + c) == term_sum)
         else $error("carry_save_tree: s + c = %0h, terms add to %0h", s + c, term_sum);
   end

endmodule

`default_nettype wire

/* rtl/column_reduce.sv */
`timescale 1ns/1ps
`default_nettype none

`include "poly_mul_macros.svh"

module column_reduce (
   input  logic                        clk,
   input  logic                        arst_n,
   input  poly_mul_pkg::product_grid_t products,
   output poly_mul_pkg::result_t       result
);

   // A shifted product never needs more than four radix slices
   localparam int MAX_SLICES = 4;

   poly_mul_pkg::column_t [`POLY_NUM_COLS-1:0][`POLY_NUM_ROWS-1:0] grid;
   poly_mul_pkg::column_t [`POLY_NUM_COLS-3:0]                     tree_c;
   poly_mul_pkg::column_t [`POLY_NUM_COLS-3:0]                     tree_s;

   // Products fill a parallelogram and the rest of the grid stays zero
   always_comb begin
      logic [MAX_SLICES*`POLY_RADIX-1:0] shifted;
      int col0;
      int row0;
      int nrows;
      grid = '0;
      for (int k = 0; k < `POLY_NUM_LG; k++) begin
         col0  = poly_mul_pkg::lg_index_of(k);
         row0  = poly_mul_pkg::grid_row_of(k);
         nrows = poly_mul_pkg::grid_row_of(k + 1) - row0;
         for (int j = 0; j < `POLY_NUM_LIMBS; j++) begin
            // Align the product to the radix grid of its large word
            shifted = '0;
            shifted[$bits(poly_mul_pkg::product_t)-1:0] = products[k][j];
            shifted = shifted << poly_mul_pkg::lg_offset_of(k);
            for (int r = 0; r < MAX_SLICES; r++) begin
               if (r < nrows) begin
                  grid[col0+j+r][row0+r] =
                     poly_mul_pkg::column_t'(shifted[r*`POLY_RADIX +: `POLY_RADIX]);
               end
            end
         end
      end
   end

   // End columns hold one term each and bypass the trees
   for (genvar c = 1; c < `POLY_NUM_COLS - 1; c++) begin : g_col
      carry_save_tree i_carry_save_tree (
         .terms (grid[c]),
         .c     (tree_c[c-1]),
         .s     (tree_s[c-1])
      );
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         result <= '0;
      end else begin
         result.s[0]    <= grid[0][0];
         result.cout[0] <= '0;
         for (int c = 1; c < `POLY_NUM_COLS - 1; c++) begin
            result.s[c]    <= tree_s[c-1];
            result.cout[c] <= tree_c[c-1];
         end
         result.s[`POLY_NUM_COLS-1]    <= grid[`POLY_NUM_COLS-1][`POLY_NUM_ROWS-1];
         result.cout[`POLY_NUM_COLS-1] <= '0;
      end
   end

   // Only the bypassed row may be nonzero in each end column
   assert property (@(posedge clk) disable iff (!arst_n)
                    grid[0][`POLY_NUM_ROWS-1:1] == '0 &&
                    grid[`POLY_NUM_COLS-1][`POLY_NUM_ROWS-2:0] == '0)
      else $error("column_reduce: an end column holds more than one grid term");

endmodule

`default_nettype wire

/* rtl/limb_repack.sv */
`timescale 1ns/1ps
`default_nettype none

`include "poly_mul_macros.svh"

module limb_repack (
   input  logic                      clk,
   input  logic                      arst_n,
   input  poly_mul_pkg::operand_t    operand,
   output poly_mul_pkg::lg_operand_t lg_operand
);

   poly_mul_pkg::large_word_t [`POLY_NUM_LG-1:0] lg_next;

   for (genvar k = 0; k < `POLY_NUM_LG; k++) begin : g_word
      localparam int OFF = poly_mul_pkg::lg_offset_of(k);
      localparam int IDX = poly_mul_pkg::lg_index_of(k);
      // Where the second and third spanned limbs land in the word
      localparam int SH2 = `POLY_RADIX - OFF;
      localparam int SH3 = 2 * `POLY_RADIX - OFF;

      poly_mul_pkg::large_word_t first_w;
      poly_mul_pkg::large_word_t second_w;
      poly_mul_pkg::large_word_t third_w;
      poly_mul_pkg::large_word_t spill_first;
      poly_mul_pkg::large_word_t spill_sec;
      poly_mul_pkg::large_word_t spill_prev;
      logic [`POLY_LG_BITS:0]    word_sum;

      // Radix bits of the first limb above the word boundary
      assign first_w = poly_mul_pkg::large_word_t'(operand.a[IDX][`POLY_RADIX-1:0] >> OFF);

      assign spill_first =
         poly_mul_pkg::large_word_t'(operand.a[IDX][`POLY_LIMB_BITS-1:`POLY_RADIX]) << SH2;

      // Exact fit, so the previous limb's spill has nowhere else to go
      if (k != 0 && OFF == 0) begin : g_prev
         assign spill_prev =
            poly_mul_pkg::large_word_t'(operand.a[IDX-1][`POLY_LIMB_BITS-1:`POLY_RADIX]);
      end else begin : g_no_prev
         assign spill_prev = '0;
      end

      if (IDX + 1 < `POLY_NUM_LIMBS) begin : g_second
         localparam int W2 =
            (`POLY_LG_RADIX - SH2 < `POLY_RADIX) ? `POLY_LG_RADIX - SH2 : `POLY_RADIX;
         localparam poly_mul_pkg::large_word_t M2 = poly_mul_pkg::large_word_t'({W2{1'b1}});

         assign second_w = (poly_mul_pkg::large_word_t'(operand.a[IDX+1]) & M2) << SH2;
      end else begin : g_no_second
         assign second_w = '0;
      end

      if (SH3 < `POLY_LG_RADIX && IDX + 2 < `POLY_NUM_LIMBS) begin : g_third
         localparam int W3 = `POLY_LG_RADIX - SH3;
         localparam poly_mul_pkg::large_word_t M3 = poly_mul_pkg::large_word_t'({W3{1'b1}});

         assign third_w   = (poly_mul_pkg::large_word_t'(operand.a[IDX+2]) & M3) << SH3;
         assign spill_sec =
            poly_mul_pkg::large_word_t'(operand.a[IDX+1][`POLY_LIMB_BITS-1:`POLY_RADIX]) << SH3;
      end else if (k == `POLY_NUM_LG - 1 && IDX + 1 < `POLY_NUM_LIMBS) begin : g_last
         // Top word keeps the spill of its last limb
         assign third_w   = '0;
         assign spill_sec =
            poly_mul_pkg::large_word_t'(operand.a[IDX+1][`POLY_LIMB_BITS-1:`POLY_RADIX]) << SH3;
      end else begin : g_no_third
         assign third_w   = '0;
         assign spill_sec = '0;
      end

      assign word_sum = {1'b0, first_w | second_w | third_w} +
                        {1'b0, spill_first | spill_sec | spill_prev};
      assign lg_next[k] = word_sum[`POLY_LG_BITS-1:0];

      assert property (@(posedge clk) disable iff (!arst_n) word_sum[`POLY_LG_BITS] == 1'b0)
         else $error("limb_repack: large word %0d needs more than %0d bits", k, `POLY_LG_BITS);
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lg_operand <= '0;
      end else begin
         lg_operand.lg <= lg_next;
         lg_operand.b  <= operand.b;
      end
   end

endmodule

`default_nettype wire

/* rtl/poly_mul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module poly_mul_top (
   input  logic                   clk,
   input  logic                   arst_n,
   input  poly_mul_pkg::operand_t operand,
   output poly_mul_pkg::result_t  result
);

   poly_mul_pkg::lg_operand_t   lg_operand;
   poly_mul_pkg::product_grid_t products;

   // Fold A into large words
   limb_repack i_limb_repack (
      .clk        (clk),
      .arst_n     (arst_n),
      .operand    (operand),
      .lg_operand (lg_operand)
   );

   product_array i_product_array (
      .clk        (clk),
      .arst_n     (arst_n),
      .lg_operand (lg_operand),
      .products   (products)
   );

   // Grid placement and per-column compression
   column_reduce i_column_reduce (
      .clk      (clk),
      .arst_n   (arst_n),
      .products (products),
      .result   (result)
   );

endmodule

`default_nettype wire

/* rtl/product_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "poly_mul_macros.svh"

module product_array (
   input  logic                        clk,
   input  logic                        arst_n,
   input  poly_mul_pkg::lg_operand_t   lg_operand,
   output poly_mul_pkg::product_grid_t products
);

   poly_mul_pkg::product_grid_t products_next;

   // Every large word against every B limb
   always_comb begin
      for (int k = 0; k < `POLY_NUM_LG; k++) begin
         for (int j = 0; j < `POLY_NUM_LIMBS; j++) begin
            products_next[k][j] = lg_operand.lg[k] * lg_operand.b[j];
         end
      end
   end

   // Pipeline break between the multipliers and the adder grid
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         products <= '0;
      end else begin
         products <= products_next;
      end
   end

endmodule

`default_nettype wire
